// ==== Makefile ====
TOP = tb_rv_core

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f filelist.f

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f filelist.f
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir

// ==== filelist.f ====
+incdir+include
verilog/rv_pkg.sv
verilog/rv_pipe_if.sv
verilog/rv_fetch.sv
verilog/rv_decode.sv
verilog/rv_execute.sv
verilog/rv_result.sv
verilog/rv_core.sv
tests/rv_core_props.sv
tests/rv_checker.sv
tests/tb_rv_core.sv

// ==== include/rv_params.svh ====
// rv32i core parameters
// widths, reset vector and the major opcodes decoded by the core
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

`define RV_XLEN        32             // data and address width
`define RV_REG_AW      5              // register address width
`define RV_PC_RESET    32'h0000_0000  // first fetch address

////////////////////////////////////////////////////////////////////////////
// major opcodes, instr[6:0]
////////////////////////////////////////////////////////////////////////////
`define RV_OPC_OP      7'b0110011     // register-register alu
`define RV_OPC_OPIMM   7'b0010011     // register-immediate alu
`define RV_OPC_LUI     7'b0110111
`define RV_OPC_AUIPC   7'b0010111
`define RV_OPC_BRANCH  7'b1100011     // beq .. bgeu
`define RV_OPC_JAL     7'b1101111
`define RV_OPC_JALR    7'b1100111
`define RV_OPC_STORE   7'b0100011     // sb, sh, sw

`endif

// ==== tests/rv_checker.sv ====
// rv32i store checker
// instruction-set model of the program, in-order store comparison and counts
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_checker (
  input  logic        i_clk,
  input  logic        i_start,            // new program loaded and core out of reset
  input  logic        i_end,
  input  logic [31:0] i_prog [0:63],
  input  logic        i_wb_stb,
  input  logic        i_wb_ack,
  input  logic [31:0] i_wb_addr,
  input  logic [31:0] i_wb_data,
  input  logic [3:0]  i_wb_sel,
  output logic        o_done,
  output int          o_errors
);

  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  logic [3:0]  exp_sel  [$];
  int          test_num;
  int          test_err;
  int          n_stores;
  int          seen;

  function automatic logic [31:0] alu(logic [2:0] f3, logic alt, logic [31:0] a,
                                      logic [31:0] b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return {31'b0, $signed(a) < $signed(b)};
      3'd3: return {31'b0, a < b};
      3'd4: return a ^ b;
      3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic taken(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      default: return a >= b;
    endcase
  endfunction

  // walks the program from the reset pc up to the jump to self
  task automatic run_model();
    logic [31:0] x [0:31];
    logic [31:0] pc;
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] nxt;
    logic [31:0] rdv;
    logic [31:0] ad;
    logic [31:0] imm_i;
    logic        wr;
    int          steps;
    for (int r = 0; r < 32; r++) x[r] = '0;
    exp_addr.delete();
    exp_data.delete();
    exp_sel.delete();
    pc    = `RV_PC_RESET;
    steps = 0;
    w     = i_prog[pc[7:2]];
    while (w != 32'h0000_006f && steps < 1000) begin
      a     = x[w[19:15]];
      b     = x[w[24:20]];
      imm_i = {{20{w[31]}}, w[31:20]};
      nxt   = pc + 32'd4;
      rdv   = pc + 32'd4;           // link value
      wr    = 1'b1;
      case (w[6:0])
        `RV_OPC_OP:    rdv = alu(w[14:12], w[30], a, b);
        `RV_OPC_OPIMM: rdv = alu(w[14:12], w[14:12] == 3'd5 && w[30], a, imm_i);
        `RV_OPC_LUI:   rdv = {w[31:12], 12'b0};
        `RV_OPC_AUIPC: rdv = pc + {w[31:12], 12'b0};
        `RV_OPC_JAL:   nxt = pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        `RV_OPC_JALR:  nxt = (a + imm_i) & ~32'd1;
        `RV_OPC_BRANCH: begin
          wr = 1'b0;
          if (taken(w[14:12], a, b)) nxt = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        end
        `RV_OPC_STORE: begin
          wr = 1'b0;
          ad = a + {{20{w[31]}}, w[31:25], w[11:7]};
          exp_addr.push_back({ad[31:2], 2'b00});
          case (w[13:12])
            2'd0: begin
              exp_data.push_back({4{b[7:0]}});
              exp_sel.push_back(4'b0001 << ad[1:0]);
            end
            2'd1: begin
              exp_data.push_back({2{b[15:0]}});
              exp_sel.push_back(ad[1] ? 4'b1100 : 4'b0011);
            end
            default: begin
              exp_data.push_back(b);
              exp_sel.push_back(4'b1111);
            end
          endcase
        end
        default: wr = 1'b0;         // unknown opcode does nothing
      endcase
      if (wr && w[11:7] != 5'd0) x[w[11:7]] = rdv;
      pc    = nxt;
      w     = i_prog[pc[7:2]];
      steps = steps + 1;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // bus watch
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    o_done   = 1'b0;
    o_errors = 0;
    test_num = 0;
    n_stores = 0;
  end

  always @(posedge i_clk) begin
    if (i_start) begin
      run_model();
      test_num = test_num + 1;
      test_err = 0;
      seen     = 0;
      o_done   = 1'b0;
    end else if (i_wb_stb && i_wb_ack) begin   // store completes this cycle
      if (exp_addr.size() == 0) begin
        $display("ERR %0t: unexpected store addr %h data %h sel %b", $time, i_wb_addr,
                 i_wb_data, i_wb_sel);
        o_errors = o_errors + 1;
        test_err = test_err + 1;
      end else begin
        if (i_wb_addr !== exp_addr[0] || i_wb_data !== exp_data[0] || i_wb_sel !== exp_sel[0])
        begin
          $display("ERR %0t: store %0d got %h/%h/%b, expected %h/%h/%b", $time, seen,
                   i_wb_addr, i_wb_data, i_wb_sel, exp_addr[0], exp_data[0], exp_sel[0]);
          o_errors = o_errors + 1;
          test_err = test_err + 1;
        end
        void'(exp_addr.pop_front());
        void'(exp_data.pop_front());
        void'(exp_sel.pop_front());
        seen     = seen + 1;
        n_stores = n_stores + 1;
      end
    end
    if (!o_done && test_num > 0 && exp_addr.size() == 0) begin
      $display("test %0d done: %0d stores, %0d errors", test_num, seen, test_err);
      o_done = 1'b1;
    end
    if (i_end) begin
      $display("%0d tests, %0d stores checked, %0d errors", test_num, n_stores, o_errors);
    end
  end

endmodule

// ==== tests/rv_core_props.sv ====
// rv32i bus protocol properties
// bound into the core, reset state and strobe handshakes on both buses
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_core_props (
  input logic                i_clk,
  input logic                i_rst_n,
  input logic                o_stb_instr,
  input logic                i_ack_instr,
  input logic [`RV_XLEN-1:0] o_iaddr,
  input logic                o_wb_stb_data,
  input logic                i_wb_ack,
  input logic [`RV_XLEN-1:0] o_wb_addr_data,
  input logic [`RV_XLEN-1:0] o_wb_data_data,
  input logic [3:0]          o_wb_sel_data
);

  // first cycle out of reset, fetch at the reset vector, no store
  reset_state: assert property (@(posedge i_clk)
    $rose(i_rst_n) |-> !o_wb_stb_data && o_stb_instr && o_iaddr == `RV_PC_RESET)
    else $error("bus state wrong after reset");

  iaddr_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_stb_instr && !i_ack_instr |=> $stable(o_iaddr))
    else $error("instruction address moved while waiting");

  store_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_wb_stb_data && !i_wb_ack |=> o_wb_stb_data && $stable(o_wb_addr_data) &&
    $stable(o_wb_data_data) && $stable(o_wb_sel_data))
    else $error("store dropped or changed while waiting");

  store_drop: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_wb_stb_data && i_wb_ack |=> !o_wb_stb_data)
    else $error("store strobe still high after ack");

endmodule

bind rv_core rv_core_props props_inst (
  .i_clk (i_clk), .i_rst_n (i_rst_n), .o_stb_instr (o_stb_instr),
  .i_ack_instr (i_ack_instr), .o_iaddr (o_iaddr), .o_wb_stb_data (o_wb_stb_data),
  .i_wb_ack (i_wb_ack), .o_wb_addr_data (o_wb_addr_data),
  .o_wb_data_data (o_wb_data_data), .o_wb_sel_data (o_wb_sel_data)
);

// ==== tests/tb_rv_core.sv ====
// rv32i core testbench
// random programs, memory models with random latency, test sequencing and timeout
`timescale 1ns/1ps
`include "rv_params.svh"

module tb_rv_core;

  localparam int NUM_TESTS  = 4;
  localparam int PROG_LEN   = 64;
  localparam int MAX_CYCLES = NUM_TESTS * PROG_LEN * 12;

  logic        clk;
  logic        rst_n;
  logic [31:0] instr;
  logic [31:0] iaddr;
  logic        stb_instr;
  logic        ack_instr;
  logic        wb_stb;
  logic [31:0] wb_addr;
  logic [31:0] wb_data;
  logic [3:0]  wb_sel;
  logic        wb_ack;
  logic [31:0] prog [0:PROG_LEN-1];   // shared by both memory ports
  logic        start;                 // pulses for one cycle once the program is ready
  logic        finish_run;
  logic        done;
  int          errors;
  integer      seed;
  int          cycles;
  int          i_wait;                // remaining ack delay on the instruction side
  int          d_wait;                // remaining ack delay on the data side

  rv_core rv_core_inst (
    .i_clk (clk), .i_rst_n (rst_n), .i_instr (instr), .o_iaddr (iaddr),
    .o_stb_instr (stb_instr), .i_ack_instr (ack_instr), .o_wb_stb_data (wb_stb),
    .o_wb_addr_data (wb_addr), .o_wb_data_data (wb_data), .o_wb_sel_data (wb_sel),
    .i_wb_ack (wb_ack)
  );

  rv_checker checker_inst (
    .i_clk (clk), .i_start (start), .i_end (finish_run), .i_prog (prog),
    .i_wb_stb (wb_stb), .i_wb_ack (wb_ack), .i_wb_addr (wb_addr), .i_wb_data (wb_data),
    .i_wb_sel (wb_sel), .o_done (done), .o_errors (errors)
  );

  always #5 clk = ~clk;

  function automatic int rnd(int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // memory models ack after 0..3 cycles while the strobe is up
  ////////////////////////////////////////////////////////////////////////////
  always @(posedge clk) begin
    ack_instr <= 1'b0;
    if (stb_instr && !ack_instr) begin
      if (i_wait == 0) begin
        ack_instr <= 1'b1;
        instr     <= prog[iaddr[7:2]];  // addr past the end wraps and is only wrong path
        i_wait    <= rnd(4);
      end else begin
        i_wait <= i_wait - 1;
      end
    end
  end

  always @(posedge clk) begin
    wb_ack <= 1'b0;
    if (wb_stb && !wb_ack) begin
      if (d_wait == 0) begin
        wb_ack <= 1'b1;
        d_wait <= rnd(4);
      end else begin
        d_wait <= d_wait - 1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // program generation
  ////////////////////////////////////////////////////////////////////////////
  task automatic gen_program();
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [11:0] imm;
    int          off;
    for (int k = 0; k < 7; k++) begin  // prologue of addi x1..x7
      imm     = 12'(rnd(4096));
      prog[k] = {imm, 5'd0, 3'b000, 5'(k + 1), `RV_OPC_OPIMM};
    end
    for (int k = 7; k < PROG_LEN - 1; k++) begin
      rd  = 5'(1 + rnd(7));
      rs1 = 5'(rnd(8));     // small register set gives lots of chains
      rs2 = 5'(rnd(8));
      f3  = 3'(rnd(8));
      imm = 12'(rnd(4096));
      off = 2 + rnd(6);      // forward only
      case (rnd(16))
        0, 1, 2: prog[k] = {((f3 == 3'd0 || f3 == 3'd5) && rnd(2) == 1) ? 7'h20 : 7'h00,
                            rs2, rs1, f3, rd, `RV_OPC_OP};
        3, 4, 5: begin
          if (f3 == 3'd1) imm[11:5] = 7'h00;
          if (f3 == 3'd5) imm[11:5] = (rnd(2) == 1) ? 7'h20 : 7'h00;  // srli or srai
          prog[k] = {imm, rs1, f3, rd, `RV_OPC_OPIMM};
        end
        6:  prog[k] = {20'(rnd(1 << 20)), rd, `RV_OPC_LUI};
        7:  prog[k] = {20'(rnd(1 << 20)), rd, `RV_OPC_AUIPC};
        12, 13: begin
          if (f3 == 3'd2 || f3 == 3'd3) f3 = 3'd0;
          prog[k] = (k + off < PROG_LEN) ?
                    enc_b(13'(off * 4), rs2, rs1, f3) : enc_s(imm, rs2, rs1, 3'(rnd(3)));
        end
        14: prog[k] = (k + off < PROG_LEN) ?
                      enc_j(21'(off * 4), rd) : enc_s(imm, rs2, rs1, 3'(rnd(3)));
        15: prog[k] = (k + off < PROG_LEN) ?  // absolute target with bit 0 sometimes set
                      {12'(4 * (k + off) + rnd(2)), 5'd0, 3'b000, rd, `RV_OPC_JALR} :
                      enc_s(imm, rs2, rs1, 3'(rnd(3)));
        default: prog[k] = enc_s(imm, rs2, rs1, 3'(rnd(3)));  // sb, sh, sw
      endcase
    end
    prog[PROG_LEN-1] = enc_j(21'd0, 5'd0);  // jump to self
  endtask

  function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], `RV_OPC_STORE};
  endfunction

  function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `RV_OPC_BRANCH};
  endfunction

  function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `RV_OPC_JAL};
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // sequencing and timeout
  ////////////////////////////////////////////////////////////////////////////
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("run timed out after %0d cycles, the core stopped producing stores", cycles);
      $display("TESTS FAILED");
      $finish;
    end
  end

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    instr      = '0;
    ack_instr  = 1'b0;
    wb_ack     = 1'b0;
    start      = 1'b0;
    finish_run = 1'b0;
    seed       = 32'h3251;
    cycles     = 0;
    i_wait     = 0;
    d_wait     = 0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      rst_n <= 1'b0;
      gen_program();
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;
      start <= 1'b1;        // checker runs its model
      @(posedge clk);
      start <= 1'b0;
      @(posedge clk);
      wait (done);
      @(posedge clk);
    end
    finish_run <= 1'b1;
    @(posedge clk);
    finish_run <= 1'b0;
    @(posedge clk);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog/rv_core.sv ====
// rv32i core top level
// four-stage pipeline, fetch, decode, execute and result
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_core (
  input  logic                i_clk,
  input  logic                i_rst_n,
  input  logic [`RV_XLEN-1:0] i_instr,
  output logic [`RV_XLEN-1:0] o_iaddr,
  output logic                o_stb_instr,
  input  logic                i_ack_instr,
  output logic                o_wb_stb_data,
  output logic [`RV_XLEN-1:0] o_wb_addr_data,
  output logic [`RV_XLEN-1:0] o_wb_data_data,
  output logic [3:0]          o_wb_sel_data,
  input  logic                i_wb_ack
);

  logic                  stall;        // store waiting for ack
  logic                  redirect;
  logic [`RV_XLEN-1:0]   redirect_pc;
  logic                  f_valid;      // fetch to decode
  logic [`RV_XLEN-1:0]   f_instr;
  logic [`RV_XLEN-1:0]   f_pc;
  logic                  wr_en;        // result to register file
  logic [`RV_REG_AW-1:0] wr_addr;
  logic [`RV_XLEN-1:0]   wr_data;

  dec_exe_if dec_exe_bus ();
  exe_res_if exe_res_bus ();

  rv_fetch fetch_inst (
    .i_clk (i_clk), .i_rst_n (i_rst_n), .i_stall (stall),
    .i_redirect (redirect), .i_redirect_pc (redirect_pc),
    .i_instr (i_instr), .i_ack_instr (i_ack_instr),
    .o_iaddr (o_iaddr), .o_stb_instr (o_stb_instr),
    .o_valid (f_valid), .o_instr (f_instr), .o_pc (f_pc)
  );

  rv_decode decode_inst (
    .i_clk (i_clk), .i_rst_n (i_rst_n), .i_stall (stall), .i_flush (redirect),
    .i_valid (f_valid), .i_instr (f_instr), .i_pc (f_pc),
    .i_wr_en (wr_en), .i_wr_addr (wr_addr), .i_wr_data (wr_data),
    .fwd (exe_res_bus.res), .dx (dec_exe_bus.dec)
  );

  rv_execute execute_inst (
    .i_clk (i_clk), .i_rst_n (i_rst_n), .i_stall (stall),
    .dx (dec_exe_bus.exe), .xr (exe_res_bus.exe),
    .o_redirect (redirect), .o_redirect_pc (redirect_pc)
  );

  rv_result result_inst (
    .i_clk (i_clk), .i_rst_n (i_rst_n), .xr (exe_res_bus.res), .i_wb_ack (i_wb_ack),
    .o_wr_en (wr_en), .o_wr_addr (wr_addr), .o_wr_data (wr_data), .o_stall (stall),
    .o_wb_stb_data (o_wb_stb_data), .o_wb_addr_data (o_wb_addr_data),
    .o_wb_data_data (o_wb_data_data), .o_wb_sel_data (o_wb_sel_data)
  );

endmodule

// ==== verilog/rv_decode.sv ====
// rv32i decode stage
// register file, decode, operand forwarding and the decode/execute register
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_decode (
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  input  logic                  i_stall,
  input  logic                  i_flush,    // redirect, this word is wrong path
  input  logic                  i_valid,
  input  logic [`RV_XLEN-1:0]   i_instr,
  input  logic [`RV_XLEN-1:0]   i_pc,
  input  logic                  i_wr_en,    // register write from result
  input  logic [`RV_REG_AW-1:0] i_wr_addr,
  input  logic [`RV_XLEN-1:0]   i_wr_data,
  exe_res_if.res                fwd,        // instruction now in result
  dec_exe_if.dec                dx
);
  import rv_pkg::*;

  instr_u                ins;
  alu_op_e               alu_op;
  kind_e                 kind;
  logic                  use_imm;
  logic                  use_pc;
  logic [`RV_XLEN-1:0]   imm;
  logic [`RV_XLEN-1:0]   regs [1:2**`RV_REG_AW-1]; // x1..x31
  logic [`RV_XLEN-1:0]   rs1_rd;
  logic [`RV_XLEN-1:0]   rs2_rd;
  logic [`RV_XLEN-1:0]   rs1_q;
  logic [`RV_XLEN-1:0]   rs2_q;
  logic [`RV_REG_AW-1:0] rs1_addr_q;
  logic [`RV_REG_AW-1:0] rs2_addr_q;

  assign ins = i_instr;

  ////////////////////////////////////////////////////////////////////////////
  // decode
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    kind    = KIND_NOP;  // unknown opcodes retire as no-ops
    alu_op  = ALU_ADD;
    use_imm = 1'b0;
    use_pc  = 1'b0;
    imm     = '0;
    case (ins.r_fmt.opcode)
      `RV_OPC_OP, `RV_OPC_OPIMM: begin
        kind    = KIND_ALU;
        use_imm = (ins.r_fmt.opcode == `RV_OPC_OPIMM);
        imm     = {{20{ins.i_fmt.imm_11_0[11]}}, ins.i_fmt.imm_11_0};
        case (ins.r_fmt.funct3)
          3'b000: alu_op = (!use_imm && ins.r_fmt.funct7[5]) ? ALU_SUB : ALU_ADD;
          3'b001: alu_op = ALU_SLL;
          3'b010: alu_op = ALU_SLT;
          3'b011: alu_op = ALU_SLTU;
          3'b100: alu_op = ALU_XOR;
          3'b101: alu_op = ins.r_fmt.funct7[5] ? ALU_SRA : ALU_SRL; // srai shares bit 30
          3'b110: alu_op = ALU_OR;
          default: alu_op = ALU_AND;
        endcase
      end
      `RV_OPC_LUI, `RV_OPC_AUIPC: begin
        kind    = KIND_ALU;
        use_imm = 1'b1;
        use_pc  = (ins.r_fmt.opcode == `RV_OPC_AUIPC);
        alu_op  = use_pc ? ALU_ADD : ALU_PASS_B;
        imm     = {ins.u_fmt.imm_31_12, 12'b0};
      end
      `RV_OPC_BRANCH: begin
        kind = KIND_BRANCH;
        imm  = {{19{ins.b_fmt.imm_12}}, ins.b_fmt.imm_12, ins.b_fmt.imm_11,
                ins.b_fmt.imm_10_5, ins.b_fmt.imm_4_1, 1'b0};
      end
      `RV_OPC_JAL: begin
        kind = KIND_JAL;
        imm  = {{11{ins.j_fmt.imm_20}}, ins.j_fmt.imm_20, ins.j_fmt.imm_19_12,
                ins.j_fmt.imm_11, ins.j_fmt.imm_10_1, 1'b0};
      end
      `RV_OPC_JALR: begin
        kind    = KIND_JALR;
        use_imm = 1'b1;  // alu forms rs1 + imm as the target
        imm     = {{20{ins.i_fmt.imm_11_0[11]}}, ins.i_fmt.imm_11_0};
      end
      `RV_OPC_STORE: begin
        kind    = KIND_STORE;
        use_imm = 1'b1;  // address is rs1 + imm
        imm     = {{20{ins.s_fmt.imm_11_5[6]}}, ins.s_fmt.imm_11_5, ins.s_fmt.imm_4_0};
      end
      default: ;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // register file, write from result bypassed into the read
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge i_clk) begin
    if (i_wr_en && i_wr_addr != '0) begin
      regs[i_wr_addr] <= i_wr_data;
    end
  end

  assign rs1_rd = (ins.r_fmt.rs1 == '0) ? '0 :
                  (i_wr_en && i_wr_addr == ins.r_fmt.rs1) ? i_wr_data : regs[ins.r_fmt.rs1];
  assign rs2_rd = (ins.r_fmt.rs2 == '0) ? '0 :
                  (i_wr_en && i_wr_addr == ins.r_fmt.rs2) ? i_wr_data : regs[ins.r_fmt.rs2];

  // the instruction that was in execute has moved on to result by now
  assign dx.rs1_val = (fwd.valid && fwd.rd_we && fwd.rd == rs1_addr_q) ? fwd.rd_data : rs1_q;
  assign dx.rs2_val = (fwd.valid && fwd.rd_we && fwd.rd == rs2_addr_q) ? fwd.rd_data : rs2_q;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      dx.valid <= 1'b0;
    end else if (!i_stall) begin
      dx.valid <= i_valid && !i_flush; // bubble on flush
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_stall) begin
      dx.pc      <= i_pc;
      dx.alu_op  <= alu_op;
      dx.kind    <= kind;
      dx.funct3  <= ins.r_fmt.funct3;
      dx.use_imm <= use_imm;
      dx.use_pc  <= use_pc;
      dx.imm     <= imm;
      dx.rd      <= ins.r_fmt.rd;
      rs1_q      <= rs1_rd;
      rs2_q      <= rs2_rd;
      rs1_addr_q <= ins.r_fmt.rs1;
      rs2_addr_q <= ins.r_fmt.rs2;
    end
  end

endmodule

// ==== verilog/rv_execute.sv ====
// rv32i execute stage
// alu, branch compare, redirect, store formatting and the execute/result register
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_execute (
  input  logic                i_clk,
  input  logic                i_rst_n,
  input  logic                i_stall,
  dec_exe_if.exe              dx,
  exe_res_if.exe              xr,
  output logic                o_redirect,     // one cycle pulse
  output logic [`RV_XLEN-1:0] o_redirect_pc
);
  import rv_pkg::*;

  logic [`RV_XLEN-1:0] op_a;
  logic [`RV_XLEN-1:0] op_b;
  logic [`RV_XLEN-1:0] alu_y;
  logic [`RV_XLEN-1:0] st_data;
  logic [3:0]          st_sel;
  logic                cond;     // branch condition holds
  logic                is_jump;
  logic                rd_we;

  assign op_a = dx.use_pc ? dx.pc : dx.rs1_val;
  assign op_b = dx.use_imm ? dx.imm : dx.rs2_val;

  always_comb begin
    case (dx.alu_op)
      ALU_SUB:    alu_y = op_a - op_b;
      ALU_SLL:    alu_y = op_a << op_b[4:0];
      ALU_SLT:    alu_y = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_SLTU:   alu_y = {{(`RV_XLEN-1){1'b0}}, op_a < op_b};
      ALU_XOR:    alu_y = op_a ^ op_b;
      ALU_SRL:    alu_y = op_a >> op_b[4:0];
      ALU_SRA:    alu_y = $signed(op_a) >>> op_b[4:0];
      ALU_OR:     alu_y = op_a | op_b;
      ALU_AND:    alu_y = op_a & op_b;
      ALU_PASS_B: alu_y = op_b;      // lui
      default:    alu_y = op_a + op_b;
    endcase
  end

  always_comb begin
    case (dx.funct3)
      3'b000:  cond = dx.rs1_val == dx.rs2_val;
      3'b001:  cond = dx.rs1_val != dx.rs2_val;
      3'b100:  cond = $signed(dx.rs1_val) < $signed(dx.rs2_val);
      3'b101:  cond = $signed(dx.rs1_val) >= $signed(dx.rs2_val);
      3'b110:  cond = dx.rs1_val < dx.rs2_val;
      3'b111:  cond = dx.rs1_val >= dx.rs2_val;
      default: cond = 1'b0;
    endcase
  end

  assign is_jump       = (dx.kind == KIND_JAL) || (dx.kind == KIND_JALR);
  assign rd_we         = (dx.kind == KIND_ALU || is_jump) && dx.rd != '0; // x0 stays zero
  assign o_redirect    = dx.valid && !i_stall && (is_jump || (dx.kind == KIND_BRANCH && cond));
  assign o_redirect_pc = (dx.kind == KIND_JALR) ? {alu_y[`RV_XLEN-1:1], 1'b0} : dx.pc + dx.imm;

  // store lanes follow size and the low address bits
  always_comb begin
    case (dx.funct3[1:0])
      2'b00: begin
        st_data = {4{dx.rs2_val[7:0]}};
        st_sel  = 4'b0001 << alu_y[1:0];
      end
      2'b01: begin
        st_data = {2{dx.rs2_val[15:0]}};
        st_sel  = alu_y[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        st_data = dx.rs2_val;
        st_sel  = 4'b1111;
      end
    endcase
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      xr.valid <= 1'b0;
    end else if (!i_stall) begin
      xr.valid <= dx.valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_stall) begin
      xr.rd_we   <= rd_we;
      xr.rd      <= dx.rd;
      xr.rd_data <= is_jump ? dx.pc + `RV_XLEN'd4 : alu_y; // link value for jumps
      xr.st_en   <= (dx.kind == KIND_STORE);
      xr.st_addr <= {alu_y[`RV_XLEN-1:2], 2'b00};
      xr.st_data <= st_data;
      xr.st_sel  <= st_sel;
    end
  end

endmodule

// ==== verilog/rv_fetch.sv ====
// rv32i fetch stage
// pc, instruction-memory request and redirect handling
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_fetch (
  input  logic                i_clk,
  input  logic                i_rst_n,
  input  logic                i_stall,        // store waiting on the data bus
  input  logic                i_redirect,     // taken branch or jump in execute
  input  logic [`RV_XLEN-1:0] i_redirect_pc,
  input  logic [`RV_XLEN-1:0] i_instr,
  input  logic                i_ack_instr,
  output logic [`RV_XLEN-1:0] o_iaddr,
  output logic                o_stb_instr,
  output logic                o_valid,        // o_instr holds an acked word
  output logic [`RV_XLEN-1:0] o_instr,
  output logic [`RV_XLEN-1:0] o_pc
);

  logic [`RV_XLEN-1:0] pc_q;   // address of the request on the bus
  logic                accept; // word taken this cycle

  assign o_iaddr     = pc_q;
  assign o_stb_instr = !i_stall && !i_redirect; // addr only moves with stb low or on ack
  assign accept      = o_stb_instr && i_ack_instr;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      pc_q    <= `RV_PC_RESET;
      o_valid <= 1'b0;
    end else if (i_redirect) begin
      pc_q    <= i_redirect_pc; // new request next cycle
      o_valid <= 1'b0;          // drop the wrong-path word
    end else if (!i_stall) begin
      o_valid <= accept;
      if (accept) begin
        pc_q <= pc_q + `RV_XLEN'd4;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (accept) begin
      o_instr <= i_instr;
      o_pc    <= pc_q;
    end
  end

endmodule

// ==== verilog/rv_pipe_if.sv ====
// rv32i stage-to-stage buses
// decode to execute, and execute to result
`timescale 1ns/1ps
`include "rv_params.svh"

interface dec_exe_if;
  import rv_pkg::*;

  logic                  valid;
  logic [`RV_XLEN-1:0]   pc;
  alu_op_e               alu_op;
  kind_e                 kind;
  logic [2:0]            funct3;   // branch condition or store size
  logic                  use_imm;  // operand b is the immediate
  logic                  use_pc;   // operand a is the pc
  logic [`RV_XLEN-1:0]   rs1_val;  // forwarded operands
  logic [`RV_XLEN-1:0]   rs2_val;
  logic [`RV_XLEN-1:0]   imm;
  logic [`RV_REG_AW-1:0] rd;

  modport dec (output valid, pc, alu_op, kind, funct3, use_imm, use_pc, rs1_val, rs2_val,
               imm, rd);
  modport exe (input valid, pc, alu_op, kind, funct3, use_imm, use_pc, rs1_val, rs2_val,
               imm, rd);
endinterface

interface exe_res_if;
  logic                  valid;
  logic                  rd_we;    // never set for x0
  logic [`RV_REG_AW-1:0] rd;
  logic [`RV_XLEN-1:0]   rd_data;
  logic                  st_en;
  logic [`RV_XLEN-1:0]   st_addr;  // word aligned
  logic [`RV_XLEN-1:0]   st_data;  // lanes replicated
  logic [3:0]            st_sel;

  modport exe (output valid, rd_we, rd, rd_data, st_en, st_addr, st_data, st_sel);
  modport res (input valid, rd_we, rd, rd_data, st_en, st_addr, st_data, st_sel);
endinterface

// ==== verilog/rv_pkg.sv ====
// rv32i core types
// instruction word formats and the decoded operation codes
package rv_pkg;

  // six views of one instruction word, msb first
  typedef struct packed {
    logic [6:0]  funct7;
    logic [4:0]  rs2;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0]  imm_11_5;
    logic [4:0]  rs2;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  imm_4_0;
    logic [6:0]  opcode;
  } s_fmt_t;

  typedef struct packed {
    logic        imm_12;
    logic [5:0]  imm_10_5;
    logic [4:0]  rs2;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [3:0]  imm_4_1;
    logic        imm_11;
    logic [6:0]  opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic        imm_20;
    logic [9:0]  imm_10_1;
    logic        imm_11;
    logic [7:0]  imm_19_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } instr_u;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
  } alu_op_e;

  typedef enum logic [2:0] {
    KIND_ALU, KIND_BRANCH, KIND_JAL, KIND_JALR, KIND_STORE, KIND_NOP
  } kind_e;

endpackage

// ==== verilog/rv_result.sv ====
// rv32i result stage
// register-file write and the store bus, stalling the pipeline until ack
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_result (
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  exe_res_if.res                xr,
  input  logic                  i_wb_ack,
  output logic                  o_wr_en,
  output logic [`RV_REG_AW-1:0] o_wr_addr,
  output logic [`RV_XLEN-1:0]   o_wr_data,
  output logic                  o_stall,        // freezes every stage
  output logic                  o_wb_stb_data,
  output logic [`RV_XLEN-1:0]   o_wb_addr_data,
  output logic [`RV_XLEN-1:0]   o_wb_data_data,
  output logic [3:0]            o_wb_sel_data
);

  logic st_pend; // store sitting in this stage
  logic gap_q;   // strobe low for one cycle after each ack

  assign st_pend        = xr.valid && xr.st_en;
  assign o_wb_stb_data  = st_pend && !gap_q;
  assign o_wb_addr_data = xr.st_addr;
  assign o_wb_data_data = xr.st_data;
  assign o_wb_sel_data  = xr.st_sel;
  assign o_stall        = st_pend && !(o_wb_stb_data && i_wb_ack); // released in the ack cycle

  assign o_wr_en   = xr.valid && xr.rd_we;
  assign o_wr_addr = xr.rd;
  assign o_wr_data = xr.rd_data;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      gap_q <= 1'b0;
    end else begin
      gap_q <= o_wb_stb_data && i_wb_ack; // back-to-back stores see a low cycle
    end
  end

endmodule
